//--- source/irq_types_pkg.sv
`default_nettype none

package irq_types_pkg;

	localparam int MAX_IRQ = 32;

	typedef logic [MAX_IRQ-1:0] irq_vec_t;  // one bit per line
	typedef logic [5:0] irq_num_t;          // line number, or N for none

	// byte offsets
	localparam logic [7:0] REG_STATUS   = 8'h00;
	localparam logic [7:0] REG_MASK     = 8'h04;
	localparam logic [7:0] REG_MASK_SET = 8'h08;
	localparam logic [7:0] REG_MASK_CLR = 8'h0C;
	localparam logic [7:0] REG_IRQ_NO   = 8'h10;
	localparam logic [7:0] REG_CTRL     = 8'h14;
	localparam logic [7:0] REG_TEST_IRQ = 8'h18;

	typedef struct packed {
		irq_vec_t mask;
		logic     all_en;
		logic     test_mode;
		irq_vec_t test_irq;
	} irq_cfg_t;

	typedef struct packed {
		irq_vec_t status;
		irq_num_t irq_no;
	} irq_sts_t;

	// ones on the lines that exist, 0 .. n-1
	function automatic irq_vec_t valid_lines(int unsigned n);
		return irq_vec_t'({MAX_IRQ{1'b1}} >> (MAX_IRQ - n));
	endfunction

endpackage

`default_nettype wire

//--- source/axil_pkg.sv
`default_nettype none

package axil_pkg;

	localparam int AXIL_AW = 8;
	localparam int AXIL_DW = 32;

	typedef logic [AXIL_AW-1:0] axil_addr_t;
	typedef logic [AXIL_DW-1:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// master to slave
	typedef struct packed {
		axil_addr_t             awaddr;
		logic                   awvalid;
		axil_data_t             wdata;
		logic [AXIL_DW/8-1:0]   wstrb;
		logic                   wvalid;
		logic                   bready;
		axil_addr_t             araddr;
		logic                   arvalid;
		logic                   rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic       awready;
		logic       wready;
		axil_resp_t bresp;
		logic       bvalid;
		logic       arready;
		axil_data_t rdata;
		axil_resp_t rresp;
		logic       rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

//--- source/irq_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module irq_reg_block
	import irq_types_pkg::*, axil_pkg::*;
#(
	parameter int N = 16
) (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  axil_req_t axil_req_i,
	output axil_rsp_t axil_rsp_o,
	input  irq_sts_t  sts_i,
	output irq_cfg_t  cfg_o
);

	localparam irq_vec_t LINES = valid_lines(N);

	irq_vec_t mask_q;
	irq_vec_t test_irq_q;
	logic all_en_q;
	logic test_mode_q;

	logic wr_acc;
	logic rd_acc;
	logic bvalid_q;
	logic rvalid_q;
	axil_resp_t bresp_q;
	axil_resp_t rresp_q;
	axil_data_t rdata_q;
	axil_resp_t wr_resp;
	axil_resp_t rd_resp;
	axil_data_t rd_data;

	// one outstanding transfer per direction
	assign wr_acc = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
	assign rd_acc = axil_req_i.arvalid & ~rvalid_q;

	always_comb begin
		wr_resp = RESP_OKAY;
		case (axil_req_i.awaddr)
			REG_STATUS, REG_MASK, REG_IRQ_NO: wr_resp = RESP_OKAY;  // read-only, ignored
			REG_MASK_SET, REG_MASK_CLR, REG_CTRL, REG_TEST_IRQ: wr_resp = RESP_OKAY;
			default: wr_resp = RESP_SLVERR;
		endcase
	end

	// readback mux
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (axil_req_i.araddr)
			REG_STATUS:   rd_data = sts_i.status;
			REG_MASK:     rd_data = mask_q;
			REG_MASK_SET, REG_MASK_CLR: rd_data = '0;  // write-only
			REG_IRQ_NO:   rd_data = axil_data_t'(sts_i.irq_no);
			REG_CTRL:     rd_data[1:0] = {test_mode_q, all_en_q};
			REG_TEST_IRQ: rd_data = test_irq_q;
			default:      rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mask_q <= '0;
			test_irq_q <= '0;
			all_en_q <= 1'b0;
			test_mode_q <= 1'b0;
		end else if (wr_acc) begin
			// strobes ignored, full word written
			case (axil_req_i.awaddr)
				REG_MASK_SET: mask_q <= mask_q | (axil_req_i.wdata & LINES);
				REG_MASK_CLR: mask_q <= mask_q & ~axil_req_i.wdata;
				REG_CTRL: begin
					all_en_q <= axil_req_i.wdata[0];
					test_mode_q <= axil_req_i.wdata[1];
				end
				REG_TEST_IRQ: test_irq_q <= axil_req_i.wdata & LINES;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (axil_req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (axil_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	// response payload, only meaningful with its valid
	always_ff @(posedge clk_i) begin
		if (wr_acc)
			bresp_q <= wr_resp;
		if (rd_acc) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	always_comb begin
		axil_rsp_o.awready = wr_acc;  // aw and w taken together
		axil_rsp_o.wready = wr_acc;
		axil_rsp_o.bresp = bresp_q;
		axil_rsp_o.bvalid = bvalid_q;
		axil_rsp_o.arready = rd_acc;
		axil_rsp_o.rdata = rdata_q;
		axil_rsp_o.rresp = rresp_q;
		axil_rsp_o.rvalid = rvalid_q;
	end

	always_comb begin
		cfg_o.mask = mask_q;
		cfg_o.all_en = all_en_q;
		cfg_o.test_mode = test_mode_q;
		cfg_o.test_irq = test_irq_q;
	end

endmodule

`default_nettype wire

//--- source/irq_line_capture.sv
`timescale 1ns/1ps
`default_nettype none

module irq_line_capture
	import irq_types_pkg::*;
#(
	parameter int N = 16
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  irq_vec_t irq_i,
	input  irq_cfg_t cfg_i,
	output irq_vec_t status_o
);

	localparam irq_vec_t LINES = valid_lines(N);

	irq_vec_t src;

	// test mode swaps in the software vector
	assign src = cfg_i.test_mode ? cfg_i.test_irq : irq_i;

	// sampled every clock, no bus gating
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			status_o <= '0;
		else
			status_o <= src & LINES;  // lines above N stay zero
	end

endmodule

`default_nettype wire

//--- source/irq_prio_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module irq_prio_encoder
	import irq_types_pkg::*;
#(
	parameter int N = 16
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  irq_vec_t status_i,
	input  irq_cfg_t cfg_i,
	output irq_num_t irq_no_o,
	output logic     irq_en_o
);

	irq_vec_t masked;
	irq_num_t next_no;
	logic any_pend;

	assign masked = status_i & cfg_i.mask;
	assign any_pend = |masked;

	// walk down so the lowest set line wins
	always_comb begin
		next_no = irq_num_t'(N);  // none pending
		for (int i = N - 1; i >= 0; i--) begin
			if (masked[i])
				next_no = irq_num_t'(i);
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			irq_no_o <= irq_num_t'(N);
			irq_en_o <= 1'b0;
		end else begin
			irq_no_o <= next_no;
			irq_en_o <= any_pend & cfg_i.all_en;  // global enable gates only the output
		end
	end

endmodule

`default_nettype wire

//--- source/irq_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_top
	import irq_types_pkg::*, axil_pkg::*;
#(
	parameter int N = 16
) (
	input  logic         clk_i,
	input  logic         rst_ni,
	input  logic [N-1:0] irq_i,
	input  axil_req_t    axil_req_i,
	output axil_rsp_t    axil_rsp_o,
	output irq_num_t     irq_no_o,
	output logic         irq_en_o
);

	if (N < 1 || N > MAX_IRQ) begin : g_bad_n
		$error("N must be in 1..%0d", MAX_IRQ);
	end

	irq_vec_t irq_vec;
	irq_cfg_t cfg;
	irq_sts_t sts;

	assign irq_vec = irq_vec_t'(irq_i);  // zero-extend to full width
	assign irq_no_o = sts.irq_no;

	irq_reg_block #(.N(N)) u_regs (
		.clk_i,
		.rst_ni,
		.axil_req_i,
		.axil_rsp_o,
		.sts_i (sts),
		.cfg_o (cfg)
	);

	irq_line_capture #(.N(N)) u_capture (
		.clk_i,
		.rst_ni,
		.irq_i    (irq_vec),
		.cfg_i    (cfg),
		.status_o (sts.status)
	);

	irq_prio_encoder #(.N(N)) u_prio (
		.clk_i,
		.rst_ni,
		.status_i (sts.status),
		.cfg_i    (cfg),
		.irq_no_o (sts.irq_no),
		.irq_en_o
	);

endmodule

`default_nettype wire

//--- verification/irq_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_props
	import irq_types_pkg::*, axil_pkg::*;
#(
	parameter int N = 16
) (
	input logic      clk_i,
	input logic      rst_ni,
	input axil_req_t req_i,
	input axil_rsp_t rsp_i,
	input logic      all_en_i,
	input irq_num_t  irq_no_i,
	input logic      irq_en_i
);

	localparam irq_num_t MAX_NO = irq_num_t'(N);

	// responses wait for their ready
	bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
		else $error("rvalid dropped before rready");

	rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rsp_i.rvalid && !req_i.rready |=> $stable(rsp_i.rdata))
		else $error("rdata changed while rvalid held");

	// enable output is registered, so it follows all_en one clock later
	en_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!all_en_i |=> !irq_en_i)
		else $error("irq_en_o high with all_en clear");

	no_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
		irq_no_i <= MAX_NO)
		else $error("irq_no above N");

endmodule

bind irq_ctrl_top irq_ctrl_props #(.N(N)) u_props (
	.clk_i,
	.rst_ni,
	.req_i    (axil_req_i),
	.rsp_i    (axil_rsp_o),
	.all_en_i (cfg.all_en),
	.irq_no_i (irq_no_o),
	.irq_en_i (irq_en_o)
);

`default_nettype wire

//--- verification/irq_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_tb
	import irq_types_pkg::*, axil_pkg::*;
();

	localparam int NUM_IRQ = 16;
	localparam int LIMIT = 20;  // cycles per wait

	logic clk;
	logic rst_n;
	logic [NUM_IRQ-1:0] irq;
	axil_req_t req;
	axil_rsp_t rsp;
	irq_num_t irq_no;
	logic irq_en;

	int seed = 76;
	int errors = 0;
	int errors_seen = 0;
	int passes = 0;
	int fails = 0;

	// reference model
	logic [15:0] model_mask;
	logic [1:0] model_ctrl;  // test_mode, all_en
	logic [15:0] model_test;
	logic [15:0] model_irq;

	irq_ctrl_top #(.N(NUM_IRQ)) u_dut (
		.clk_i      (clk),
		.rst_ni     (rst_n),
		.irq_i      (irq),
		.axil_req_i (req),
		.axil_rsp_o (rsp),
		.irq_no_o   (irq_no),
		.irq_en_o   (irq_en)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t: %s got 0x%h, expected 0x%h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_hang(input string channel);
		$display("timeout: %s channel hung for %0d cycles", channel, LIMIT);
		errors++;
	endtask

	// lowest set line wins and 16 means none
	function automatic irq_num_t lowest_set(input logic [15:0] v);
		for (int i = 0; i < NUM_IRQ; i++)
			if (v[i])
				return irq_num_t'(i);
		return irq_num_t'(NUM_IRQ);
	endfunction

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		int n;
		@(posedge clk);
		req.awaddr <= addr;
		req.wdata <= data;
		req.wstrb <= '1;
		req.awvalid <= 1'b1;
		req.wvalid <= 1'b1;
		@(negedge clk);
		for (n = 0; n < LIMIT && !(rsp.awready && rsp.wready); n++)
			@(negedge clk);
		if (!(rsp.awready && rsp.wready))
			report_hang("write address/data");
		@(posedge clk);  // taken on this edge
		req.awvalid <= 1'b0;
		req.wvalid <= 1'b0;
		@(negedge clk);
		for (n = 0; n < LIMIT && !rsp.bvalid; n++)
			@(negedge clk);
		if (!rsp.bvalid)
			report_hang("write response");
		resp = rsp.bresp;
		@(posedge clk);
		req.bready <= 1'b1;  // response held back one cycle
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		int n;
		@(posedge clk);
		req.araddr <= addr;
		req.arvalid <= 1'b1;
		@(negedge clk);
		for (n = 0; n < LIMIT && !rsp.arready; n++)
			@(negedge clk);
		if (!rsp.arready)
			report_hang("read address");
		@(posedge clk);
		req.arvalid <= 1'b0;
		@(negedge clk);
		for (n = 0; n < LIMIT && !rsp.rvalid; n++)
			@(negedge clk);
		if (!rsp.rvalid)
			report_hang("read data");
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clk);
		req.rready <= 1'b1;  // data held back one cycle
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	task automatic read_expect(input axil_addr_t addr, input axil_data_t exp, input string what);
		axil_data_t data;
		axil_resp_t resp;
		axil_read(addr, data, resp);
		check_eq(what, data, exp);
		check_eq({what, " resp"}, 32'(resp), 32'(RESP_OKAY));
	endtask

	// write that must succeed and updates the model by the register rules
	task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
		axil_resp_t resp;
		axil_write(addr, data, resp);
		check_eq("write resp", 32'(resp), 32'(RESP_OKAY));
		case (addr)
			REG_MASK_SET: model_mask = model_mask | data[15:0];
			REG_MASK_CLR: model_mask = model_mask & ~data[15:0];
			REG_CTRL:     model_ctrl = data[1:0];
			REG_TEST_IRQ: model_test = data[15:0];
			default: ;
		endcase
	endtask

	task automatic drive_irq(input logic [15:0] v);
		@(posedge clk);
		irq <= v;
		model_irq = v;
	endtask

	task automatic settle_and_check(input string tag);
		logic [15:0] src;
		irq_num_t exp_no;
		logic exp_en;
		int n;
		src = model_ctrl[1] ? model_test : model_irq;
		exp_no = lowest_set(src & model_mask);
		exp_en = |(src & model_mask) && model_ctrl[0];
		@(negedge clk);
		for (n = 0; n < LIMIT && (irq_no !== exp_no || irq_en !== exp_en); n++)
			@(negedge clk);
		check_eq({tag, " irq_en_o"}, 32'(irq_en), 32'(exp_en));
		check_eq({tag, " irq_no_o"}, 32'(irq_no), 32'(exp_no));
		read_expect(REG_STATUS, 32'(src), {tag, " STATUS"});
		read_expect(REG_IRQ_NO, 32'(exp_no), {tag, " IRQ_NO"});
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, errors - errors_seen);
		if (errors == errors_seen)
			passes++;
		else
			fails++;
		errors_seen = errors;
	endtask

	initial begin : main
		axil_data_t data;
		axil_resp_t resp;
		req = '0;
		irq = '0;
		rst_n = 1'b0;
		model_mask = '0;
		model_ctrl = '0;
		model_test = '0;
		model_irq = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_eq("irq_en_o after reset", 32'(irq_en), 32'h0);
		read_expect(REG_STATUS, 32'h0, "STATUS");
		read_expect(REG_MASK, 32'h0, "MASK");
		read_expect(REG_CTRL, 32'h0, "CTRL");
		read_expect(REG_TEST_IRQ, 32'h0, "TEST_IRQ");
		read_expect(REG_IRQ_NO, 32'(NUM_IRQ), "IRQ_NO");
		finish_test("1 reset values");

		repeat (6) begin
			write_reg(REG_MASK_SET, $random(seed));
			write_reg(REG_MASK_CLR, $random(seed));
			read_expect(REG_MASK, 32'(model_mask), "MASK");
		end
		finish_test("2 mask set/clear");

		write_reg(REG_CTRL, 32'h1);
		repeat (8) begin
			write_reg(REG_MASK_CLR, 32'hffff_ffff);
			write_reg(REG_MASK_SET, $random(seed));
			drive_irq(16'($random(seed)));
			settle_and_check("priority");
		end
		finish_test("3 priority");

		write_reg(REG_MASK_SET, 32'h0000_ffff);
		write_reg(REG_TEST_IRQ, {16'ha5a5, 16'($random(seed))});  // upper half dropped
		read_expect(REG_TEST_IRQ, 32'(model_test), "TEST_IRQ");
		write_reg(REG_CTRL, 32'h3);
		drive_irq(~model_test);
		settle_and_check("test mode");
		drive_irq(16'($random(seed)));
		settle_and_check("test mode, lines moving");
		write_reg(REG_CTRL, 32'h1);
		settle_and_check("test mode off");
		finish_test("4 test mode");

		write_reg(REG_CTRL, 32'h0);
		repeat (4) begin
			drive_irq(16'($random(seed)) | 16'h8000);  // always something pending
			settle_and_check("global enable off");
		end
		finish_test("5 global enable off");

		write_reg(REG_MASK_CLR, 32'h0000_00ff);
		axil_write(8'h40, 32'hffff_ffff, resp);
		check_eq("write 0x40 resp", 32'(resp), 32'(RESP_SLVERR));
		axil_read(8'h40, data, resp);
		check_eq("read 0x40 resp", 32'(resp), 32'(RESP_SLVERR));
		read_expect(REG_MASK, 32'(model_mask), "MASK after bad write");
		finish_test("6 bad offset");

		$display("tests passed %0d, failed %0d", passes, fails);
		if (fails == 0 && errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
source/irq_types_pkg.sv
source/axil_pkg.sv
source/irq_reg_block.sv
source/irq_line_capture.sv
source/irq_prio_encoder.sv
source/irq_ctrl_top.sv
verification/irq_ctrl_props.sv
verification/irq_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module irq_ctrl_tb -o irq_ctrl_sim
out=$(./obj_dir/irq_ctrl_sim) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed"
